// ==== mtx_cfg.svh ====
`ifndef MTX_CFG_SVH
`define MTX_CFG_SVH

// Depth and timing
`define CMD_DEPTH 4
`define SYNC_LEN  16
`define SYMB_LEN  8
`define PHASE_W   16
`define IQ_W      12
`define GPIO_W    12
`define SCAN_DIV  4

// Front-panel pin positions
`define PIN_SYNC  0
`define PIN_LOAD  2
`define PIN_DATA  4
`define PIN_HOLD  5
`define PIN_PHIB  6
`define PIN_PHI   8
`define PIN_ID    10
`define PIN_TX    11

`endif

// ==== mtx_cmd_pkg.sv ====
`default_nettype none

`include "mtx_cfg.svh"

package mtx_cmd_pkg;

  localparam logic KIND_TONE = 1'b0;
  localparam logic KIND_SCAN = 1'b1;

  typedef struct packed {
    logic                kind;
    logic [6:0]          rsvd;
    logic [7:0]          nsymb;
    logic [`PHASE_W-1:0] freq_inc;
  } tone_cmd_t;

  // Payload bits leave MSB first, starting at bit nbits_m1
  typedef struct packed {
    logic        kind;
    logic [1:0]  rsvd;
    logic [4:0]  nbits_m1;
    logic [23:0] payload;
  } scan_cmd_t;

  typedef union packed {
    tone_cmd_t tone;
    scan_cmd_t scan;
  } cmd_word_t;

endpackage

`default_nettype wire

// ==== mtx_sig_pkg.sv ====
`default_nettype none

`include "mtx_cfg.svh"

package mtx_sig_pkg;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_SYNC_A,
    PH_SYNC_B,
    PH_GAP,
    PH_TX
  } sync_phase_t;

  typedef logic signed [`IQ_W-1:0] iq_t;

  // One full cosine period at 16 points, full scale 2047
  // Sine of index k is entry (k - 4) mod 16
  localparam iq_t cos_table [0:15] = '{
    12'sd2047,
    12'sd1891,
    12'sd1447,
    12'sd783,
    12'sd0,
    -12'sd783,
    -12'sd1447,
    -12'sd1891,
    -12'sd2047,
    -12'sd1891,
    -12'sd1447,
    -12'sd783,
    12'sd0,
    12'sd783,
    12'sd1447,
    12'sd1891
  };

endpackage

`default_nettype wire

// ==== cmd_intake.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mtx_cfg.svh"

module cmd_intake import mtx_cmd_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      cmd_valid,
  input  cmd_word_t cmd_word,
  input  logic      hold,
  input  logic      seq_busy,
  input  logic      scan_busy,
  output logic      cmd_credit,
  output logic      tone_start,
  output logic      scan_start,
  output cmd_word_t head_word
);

  localparam int PTR_W = $clog2(`CMD_DEPTH);
  localparam int CNT_W = $clog2(`CMD_DEPTH + 1);

  cmd_word_t        mem [0:`CMD_DEPTH-1];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             not_empty;
  logic             pop;

  assign not_empty = (count != '0);
  assign head_word = mem[rd_ptr];

  // The kind flag sits in bit 31 of both layouts
  assign tone_start = not_empty && (head_word.tone.kind == KIND_TONE) && !seq_busy && !hold;
  assign scan_start = not_empty && (head_word.scan.kind == KIND_SCAN) && !scan_busy;

  assign pop        = tone_start || scan_start;
  assign cmd_credit = pop;

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      mem[wr_ptr] <= cmd_word;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (cmd_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(cmd_valid) - CNT_W'(pop);
    end
  end

endmodule

`default_nettype wire

// ==== sync_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mtx_cfg.svh"

module sync_sequencer import mtx_cmd_pkg::*, mtx_sig_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                tone_start,
  input  cmd_word_t           head_word,
  output sync_phase_t         phase,
  output logic [`PHASE_W-1:0] freq_inc,
  output logic                seq_busy
);

  localparam int SC_W = $clog2(`SYNC_LEN);
  localparam int SY_W = $clog2(`SYMB_LEN);
  localparam logic [SC_W-1:0] SYNC_LAST = SC_W'(`SYNC_LEN - 1);
  localparam logic [SY_W-1:0] SYMB_LAST = SY_W'(`SYMB_LEN - 1);

  logic [SC_W-1:0] sync_cnt;
  logic [SY_W-1:0] symb_cnt;
  logic [7:0]      nsymb_left;

  assign seq_busy = (phase != PH_IDLE);

  always_ff @(posedge clk) begin
    if (reset) begin
      phase    <= PH_IDLE;
      sync_cnt <= '0;
      symb_cnt <= '0;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (tone_start) begin
            phase      <= PH_SYNC_A;
            sync_cnt   <= '0;
            nsymb_left <= head_word.tone.nsymb;
            freq_inc   <= head_word.tone.freq_inc;
          end
        end
        PH_SYNC_A, PH_SYNC_B, PH_GAP: begin
          if (sync_cnt == SYNC_LAST) begin
            sync_cnt <= '0;
            symb_cnt <= '0;
            if (phase == PH_SYNC_A) begin
              phase <= PH_SYNC_B;
            end else if (phase == PH_SYNC_B) begin
              phase <= PH_GAP;
            end else begin
              // A zero-length burst ends after the gap
              phase <= (nsymb_left == 8'd0) ? PH_IDLE : PH_TX;
            end
          end else begin
            sync_cnt <= sync_cnt + 1'b1;
          end
        end
        PH_TX: begin
          if (symb_cnt == SYMB_LAST) begin
            symb_cnt   <= '0;
            nsymb_left <= nsymb_left - 8'd1;
            if (nsymb_left == 8'd1) begin
              phase <= PH_IDLE;
            end
          end else begin
            symb_cnt <= symb_cnt + 1'b1;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== tone_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mtx_cfg.svh"

module tone_gen import mtx_sig_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  sync_phase_t               phase,
  input  logic [`PHASE_W-1:0]       freq_inc,
  output logic [`PHASE_W-1:0]       ph,
  output logic signed [`IQ_W-1:0]   itx,
  output logic signed [`IQ_W-1:0]   qtx,
  output logic                      tx_valid
);

  logic                in_tx;
  logic [`PHASE_W-1:0] acc;
  logic [3:0]          cos_idx;
  logic [3:0]          sin_idx;
  iq_t                 cos_val;
  iq_t                 sin_val;

  assign in_tx = (phase == PH_TX);
  assign ph    = acc;

  // Top four phase bits select one of sixteen points per period
  assign cos_idx = acc[`PHASE_W-1 -: 4];
  assign sin_idx = cos_idx - 4'd4;
  assign cos_val = cos_table[cos_idx];
  assign sin_val = cos_table[sin_idx];

  // Held at zero outside a burst, so the first transmit cycle starts at phase zero
  always_ff @(posedge clk) begin
    if (reset || !in_tx) begin
      acc <= '0;
    end else begin
      acc <= acc + freq_inc;
    end
  end

  // Samples are muted through the preamble and the gap
  always_ff @(posedge clk) begin
    if (reset) begin
      itx      <= '0;
      qtx      <= '0;
      tx_valid <= 1'b0;
    end else begin
      tx_valid <= in_tx;
      if (in_tx) begin
        itx <= cos_val;
        qtx <= sin_val;
      end else begin
        itx <= '0;
        qtx <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== scan_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mtx_cfg.svh"

module scan_shifter import mtx_cmd_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      scan_start,
  input  cmd_word_t head_word,
  output logic      scan_busy,
  output logic      scan_id,
  output logic      scan_phi,
  output logic      scan_phi_bar,
  output logic      scan_data,
  output logic      scan_load
);

  localparam int DIV_W = $clog2(`SCAN_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SCAN_DIV - 1);

  logic             busy;
  logic             loading;
  logic [1:0]       step;
  logic [DIV_W-1:0] div_cnt;
  logic [4:0]       bit_idx;
  logic [23:0]      payload;
  logic             shifting;

  // Step 0 is data setup, step 1 is phi, step 2 is phi_bar
  assign shifting     = busy && !loading;
  assign scan_busy    = busy;
  assign scan_id      = busy;
  assign scan_phi     = shifting && (step == 2'd1);
  assign scan_phi_bar = shifting && (step == 2'd2);
  assign scan_data    = shifting && payload[bit_idx];
  assign scan_load    = busy && loading;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      loading <= 1'b0;
      step    <= 2'd0;
      div_cnt <= '0;
    end else if (!busy) begin
      if (scan_start) begin
        busy    <= 1'b1;
        loading <= 1'b0;
        step    <= 2'd0;
        div_cnt <= '0;
        bit_idx <= head_word.scan.nbits_m1;
        payload <= head_word.scan.payload;
      end
    end else if (div_cnt != DIV_LAST) begin
      div_cnt <= div_cnt + 1'b1;
    end else begin
      div_cnt <= '0;
      if (loading) begin
        busy    <= 1'b0;
        loading <= 1'b0;
      end else if (step == 2'd2) begin
        step <= 2'd0;
        if (bit_idx == 5'd0) begin
          loading <= 1'b1;
        end else begin
          bit_idx <= bit_idx - 5'd1;
        end
      end else begin
        step <= step + 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== gpio_map.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mtx_cfg.svh"

module gpio_map import mtx_sig_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  sync_phase_t        phase,
  input  logic               scan_id,
  input  logic               scan_phi,
  input  logic               scan_phi_bar,
  input  logic               scan_data,
  input  logic               scan_load,
  input  logic [`GPIO_W-1:0] fp_gpio_in,
  output logic [`GPIO_W-1:0] fp_gpio_out,
  output logic [`GPIO_W-1:0] fp_gpio_ddr,
  output logic               hold
);

  localparam logic [`GPIO_W-1:0] OUT_MASK =
      (`GPIO_W'(1) << `PIN_SYNC) | (`GPIO_W'(1) << `PIN_LOAD) |
      (`GPIO_W'(1) << `PIN_DATA) | (`GPIO_W'(1) << `PIN_PHIB) |
      (`GPIO_W'(1) << `PIN_PHI)  | (`GPIO_W'(1) << `PIN_ID)   |
      (`GPIO_W'(1) << `PIN_TX);

  logic [`GPIO_W-1:0] gpio_next;
  logic               hold_meta;

  assign fp_gpio_ddr = OUT_MASK;

  always_comb begin
    gpio_next            = '0;
    gpio_next[`PIN_SYNC] = (phase == PH_SYNC_B) || (phase == PH_GAP);
    gpio_next[`PIN_TX]   = (phase == PH_TX);
    gpio_next[`PIN_ID]   = scan_id;
    gpio_next[`PIN_PHI]  = scan_phi;
    gpio_next[`PIN_PHIB] = scan_phi_bar;
    gpio_next[`PIN_DATA] = scan_data;
    gpio_next[`PIN_LOAD] = scan_load;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fp_gpio_out <= '0;
      hold_meta   <= 1'b0;
      hold        <= 1'b0;
    end else begin
      fp_gpio_out <= gpio_next;
      // Hold pin is asynchronous to clk
      hold_meta   <= fp_gpio_in[`PIN_HOLD];
      hold        <= hold_meta;
    end
  end

endmodule

`default_nettype wire

// ==== mtx_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mtx_cfg.svh"

module mtx_ctrl_top import mtx_cmd_pkg::*, mtx_sig_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cmd_valid,
  input  cmd_word_t               cmd_word,
  input  logic [`GPIO_W-1:0]      fp_gpio_in,
  output logic                    cmd_credit,
  output logic signed [`IQ_W-1:0] itx,
  output logic signed [`IQ_W-1:0] qtx,
  output logic                    tx_valid,
  output logic [`PHASE_W-1:0]     ph,
  output logic [`GPIO_W-1:0]      fp_gpio_out,
  output logic [`GPIO_W-1:0]      fp_gpio_ddr
);

  cmd_word_t           head_word;
  sync_phase_t         phase;
  logic [`PHASE_W-1:0] freq_inc;
  logic                hold;
  logic                tone_start;
  logic                scan_start;
  logic                seq_busy;
  logic                scan_busy;
  logic                scan_id;
  logic                scan_phi;
  logic                scan_phi_bar;
  logic                scan_data;
  logic                scan_load;

  cmd_intake u_cmd_intake (
    .clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd_word(cmd_word),
    .hold(hold), .seq_busy(seq_busy), .scan_busy(scan_busy),
    .cmd_credit(cmd_credit), .tone_start(tone_start), .scan_start(scan_start),
    .head_word(head_word)
  );

  sync_sequencer u_sync_sequencer (
    .clk(clk), .reset(reset), .tone_start(tone_start), .head_word(head_word),
    .phase(phase), .freq_inc(freq_inc), .seq_busy(seq_busy)
  );

  tone_gen u_tone_gen (
    .clk(clk), .reset(reset), .phase(phase), .freq_inc(freq_inc),
    .ph(ph), .itx(itx), .qtx(qtx), .tx_valid(tx_valid)
  );

  scan_shifter u_scan_shifter (
    .clk(clk), .reset(reset), .scan_start(scan_start), .head_word(head_word),
    .scan_busy(scan_busy), .scan_id(scan_id), .scan_phi(scan_phi),
    .scan_phi_bar(scan_phi_bar), .scan_data(scan_data), .scan_load(scan_load)
  );

  gpio_map u_gpio_map (
    .clk(clk), .reset(reset), .phase(phase), .scan_id(scan_id),
    .scan_phi(scan_phi), .scan_phi_bar(scan_phi_bar), .scan_data(scan_data),
    .scan_load(scan_load), .fp_gpio_in(fp_gpio_in), .fp_gpio_out(fp_gpio_out),
    .fp_gpio_ddr(fp_gpio_ddr), .hold(hold)
  );

endmodule

`default_nettype wire

// ==== tb_mtx_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mtx_cfg.svh"

module tb_mtx_ctrl import mtx_cmd_pkg::*; ();

  localparam int WAIT_LIMIT = 3000;

  logic                    clk;
  logic                    reset;
  logic                    cmd_valid;
  cmd_word_t               cmd_word;
  logic [`GPIO_W-1:0]      fp_gpio_in;
  logic                    cmd_credit;
  logic signed [`IQ_W-1:0] itx;
  logic signed [`IQ_W-1:0] qtx;
  logic                    tx_valid;
  logic [`PHASE_W-1:0]     ph;
  logic [`GPIO_W-1:0]      fp_gpio_out;
  logic [`GPIO_W-1:0]      fp_gpio_ddr;

  // Driver and scoreboard state
  int        credits;
  int        credit_pulses;
  int        sent_count;
  int        last_wait;
  int        tones_done;
  int        scans_done;
  int        cyc;
  int        rnd_seed;
  cmd_word_t sent_words [$];
  cmd_word_t tone_q [$];
  cmd_word_t scan_q [$];
  int        tone_pop_cyc [$];
  int        scan_pop_cyc [$];

  // Monitor state
  cmd_word_t           cur;
  cmd_word_t           scur;
  cmd_word_t           popped;
  int                  t0;
  int                  sync_high;
  int                  tx_count;
  int                  scan_nbits;
  int                  phib_rises;
  int                  load_cnt;
  logic                tx_armed;
  logic                sync_prev;
  logic                tx_prev;
  logic                id_prev;
  logic                phi_prev;
  logic                phib_prev;
  logic [`PHASE_W-1:0] prev_ph;
  logic [`PHASE_W-1:0] exp_ph;
  logic [31:0]         scan_bits;
  logic [31:0]         exp_bits;
  logic [`GPIO_W-1:0]  exp_ddr;

  mtx_ctrl_top UUT (
    .clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd_word(cmd_word),
    .fp_gpio_in(fp_gpio_in), .cmd_credit(cmd_credit), .itx(itx), .qtx(qtx),
    .tx_valid(tx_valid), .ph(ph), .fp_gpio_out(fp_gpio_out), .fp_gpio_ddr(fp_gpio_ddr)
  );

  always #5 clk = ~clk;

  task automatic value_fail(input string name, input longint exp, input longint act);
    $display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
    $display("TESTBENCH FAILED");
    $fatal(1, "value mismatch on %s", name);
  endtask

  task automatic plain_fail(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("TESTBENCH FAILED");
    $fatal(1, "%s", what);
  endtask

  // Full scale 2047, sixteen points per period
  function automatic int model_cos(input int k);
    real r;
    r = 2047.0 * $cos(2.0 * 3.14159265358979 * k / 16.0);
    return int'(r);
  endfunction

  function automatic int model_sin(input int k);
    real r;
    r = 2047.0 * $sin(2.0 * 3.14159265358979 * k / 16.0);
    return int'(r);
  endfunction

  function automatic cmd_word_t make_tone(input logic [7:0] nsymb, input logic [15:0] inc);
    cmd_word_t w;
    w               = '0;
    w.tone.kind     = KIND_TONE;
    w.tone.nsymb    = nsymb;
    w.tone.freq_inc = inc;
    return w;
  endfunction

  function automatic cmd_word_t make_scan(input logic [4:0] nbits_m1, input logic [23:0] bits);
    cmd_word_t w;
    w               = '0;
    w.scan.kind     = KIND_SCAN;
    w.scan.nbits_m1 = nbits_m1;
    w.scan.payload  = bits;
    return w;
  endfunction

  function automatic cmd_word_t rand_cmd();
    if ($urandom_range(0, 1) == 0) begin
      return make_tone(8'($urandom_range(1, 6)), 16'($urandom));
    end
    return make_scan(5'($urandom_range(0, 23)), 24'($urandom));
  endfunction

  // Waits for a credit, spends it and leaves cmd_valid high for one word
  task automatic send_cmd(input cmd_word_t w);
    int waited;
    waited = 0;
    @(negedge clk);
    while (credits == 0 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      cmd_valid <= 1'b0;
      @(negedge clk);
      waited++;
    end
    last_wait = waited;
    assert (credits > 0) else plain_fail("no credit came back for a pending command");
    credits--;
    sent_words.push_back(w);
    sent_count++;
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_word  <= w;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(posedge clk);
    cmd_valid <= 1'b0;
    @(negedge clk);
    while (tones_done + scans_done != sent_count && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (waited < WAIT_LIMIT) else plain_fail("commands did not all complete in time");
  endtask

  always @(posedge clk) begin
    cyc++;
    if (!reset) begin
      // Each credit belongs to the oldest command still in the FIFO
      if (cmd_credit) begin
        credit_pulses++;
        credits++;
        assert (credits <= `CMD_DEPTH) else value_fail("credits", `CMD_DEPTH, credits);
        assert (sent_words.size() > 0) else plain_fail("credit returned with nothing sent");
        popped = sent_words.pop_front();
        if (popped.scan.kind == KIND_SCAN) begin
          scan_q.push_back(popped);
          scan_pop_cyc.push_back(cyc);
        end else begin
          tone_q.push_back(popped);
          tone_pop_cyc.push_back(cyc);
        end
      end
      assert (credits >= 0) else value_fail("credits", 0, credits);

      // Pop to phase takes one clock and the pin register another
      if (fp_gpio_out[`PIN_SYNC] && !sync_prev) begin
        assert (tone_q.size() > 0) else plain_fail("sync pin rose without a tone command");
        cur = tone_q.pop_front();
        t0  = tone_pop_cyc.pop_front();
        assert (cyc - t0 == `SYNC_LEN + 2)
          else value_fail("fp_gpio_out sync rise delay", `SYNC_LEN + 2, cyc - t0);
        sync_high = 0;
      end
      if (fp_gpio_out[`PIN_SYNC]) begin
        sync_high++;
        if (sync_high > `SYNC_LEN) begin
          assert (itx == 0) else value_fail("itx in gap", 0, itx);
          assert (qtx == 0) else value_fail("qtx in gap", 0, qtx);
          assert (!tx_valid) else value_fail("tx_valid in gap", 0, tx_valid);
        end
      end
      if (!fp_gpio_out[`PIN_SYNC] && sync_prev) begin
        assert (sync_high == 2 * `SYNC_LEN)
          else value_fail("fp_gpio_out sync high length", 2 * `SYNC_LEN, sync_high);
        if (cur.tone.nsymb == 8'd0) begin
          tones_done++;
        end else begin
          tx_armed = 1'b1;
        end
      end

      assert (tx_valid == fp_gpio_out[`PIN_TX])
        else value_fail("fp_gpio_out tx pin", tx_valid, fp_gpio_out[`PIN_TX]);
      if (tx_valid) begin
        if (!tx_prev) begin
          assert (tx_armed) else plain_fail("tx_valid rose outside a burst");
          tx_armed = 1'b0;
          exp_ph   = '0;
          tx_count = 0;
        end
        tx_count++;
        assert (prev_ph == exp_ph) else value_fail("ph", exp_ph, prev_ph);
        assert (itx == model_cos(prev_ph[`PHASE_W-1 -: 4]))
          else value_fail("itx", model_cos(prev_ph[`PHASE_W-1 -: 4]), itx);
        assert (qtx == model_sin(prev_ph[`PHASE_W-1 -: 4]))
          else value_fail("qtx", model_sin(prev_ph[`PHASE_W-1 -: 4]), qtx);
        exp_ph = exp_ph + cur.tone.freq_inc;
      end else if (tx_prev) begin
        assert (tx_count == cur.tone.nsymb * `SYMB_LEN)
          else value_fail("tx_valid length", cur.tone.nsymb * `SYMB_LEN, tx_count);
        tones_done++;
      end

      assert (!(fp_gpio_out[`PIN_PHI] && fp_gpio_out[`PIN_PHIB]))
        else plain_fail("phi and phi_bar are high together");
      if (fp_gpio_out[`PIN_ID] && !id_prev) begin
        assert (scan_q.size() > 0) else plain_fail("scan started without a scan command");
        scur = scan_q.pop_front();
        t0   = scan_pop_cyc.pop_front();
        assert (cyc - t0 == 2) else value_fail("fp_gpio_out id rise delay", 2, cyc - t0);
        scan_bits  = '0;
        scan_nbits = 0;
        phib_rises = 0;
        load_cnt   = 0;
      end
      if (fp_gpio_out[`PIN_ID] && fp_gpio_out[`PIN_PHI] && !phi_prev) begin
        scan_bits = {scan_bits[30:0], fp_gpio_out[`PIN_DATA]};
        scan_nbits++;
      end
      if (fp_gpio_out[`PIN_ID] && fp_gpio_out[`PIN_PHIB] && !phib_prev) begin
        phib_rises++;
      end
      if (fp_gpio_out[`PIN_ID] && fp_gpio_out[`PIN_LOAD]) begin
        load_cnt++;
      end
      if (!fp_gpio_out[`PIN_ID] && id_prev) begin
        exp_bits = 32'(scur.scan.payload) & ((32'h1 << (scur.scan.nbits_m1 + 1)) - 1);
        assert (scan_nbits == scur.scan.nbits_m1 + 1)
          else value_fail("scan bit count", scur.scan.nbits_m1 + 1, scan_nbits);
        assert (phib_rises == scur.scan.nbits_m1 + 1)
          else value_fail("fp_gpio_out phi_bar pulses", scur.scan.nbits_m1 + 1, phib_rises);
        assert (scan_bits == exp_bits) else value_fail("scan data bits", exp_bits, scan_bits);
        assert (load_cnt == `SCAN_DIV) else value_fail("scan load length", `SCAN_DIV, load_cnt);
        scans_done++;
      end
    end
    sync_prev = fp_gpio_out[`PIN_SYNC];
    tx_prev   = tx_valid;
    id_prev   = fp_gpio_out[`PIN_ID];
    phi_prev  = fp_gpio_out[`PIN_PHI];
    phib_prev = fp_gpio_out[`PIN_PHIB];
    prev_ph   = ph;
  end

  initial begin
    rnd_seed      = $urandom(32'h270db245);
    clk           = 1'b0;
    reset         = 1'b1;
    cmd_valid     = 1'b0;
    cmd_word      = '0;
    fp_gpio_in    = '0;
    credits       = `CMD_DEPTH;
    credit_pulses = 0;
    sent_count    = 0;
    tones_done    = 0;
    scans_done    = 0;
    cyc           = 0;
    tx_armed      = 1'b0;
    exp_ddr       = `GPIO_W'((1 << `PIN_SYNC) | (1 << `PIN_LOAD) | (1 << `PIN_DATA) |
                             (1 << `PIN_PHIB) | (1 << `PIN_PHI) | (1 << `PIN_ID) |
                             (1 << `PIN_TX));
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (fp_gpio_out == '0) else value_fail("fp_gpio_out after reset", 0, fp_gpio_out);
    assert (!tx_valid) else value_fail("tx_valid after reset", 0, tx_valid);
    assert (itx == 0) else value_fail("itx after reset", 0, itx);
    assert (qtx == 0) else value_fail("qtx after reset", 0, qtx);
    assert (!cmd_credit) else value_fail("cmd_credit after reset", 0, cmd_credit);
    assert (fp_gpio_ddr == exp_ddr) else value_fail("fp_gpio_ddr", exp_ddr, fp_gpio_ddr);

    send_cmd(make_tone(8'($urandom_range(1, 6)), 16'($urandom)));
    send_cmd(make_scan(5'($urandom_range(0, 23)), 24'($urandom)));
    send_cmd(make_tone(8'd0, 16'h1234));
    wait_idle();

    // A tone command held off by the hold pin
    @(posedge clk);
    fp_gpio_in[`PIN_HOLD] <= 1'b1;
    repeat (4) @(posedge clk);
    send_cmd(make_tone(8'($urandom_range(1, 6)), 16'($urandom)));
    @(posedge clk);
    cmd_valid <= 1'b0;
    for (int i = 0; i < 200; i++) begin
      @(negedge clk);
      assert (!fp_gpio_out[`PIN_SYNC] && !tx_valid) else plain_fail("burst started during hold");
    end
    @(posedge clk);
    fp_gpio_in[`PIN_HOLD] <= 1'b0;
    wait_idle();

    // Keep both consumers busy, then fill the FIFO
    send_cmd(make_tone(8'd40, 16'($urandom)));
    send_cmd(make_scan(5'd23, 24'($urandom)));
    @(posedge clk);
    cmd_valid <= 1'b0;
    repeat (5) @(posedge clk);
    send_cmd(make_tone(8'($urandom_range(1, 6)), 16'($urandom)));
    send_cmd(make_scan(5'($urandom_range(0, 23)), 24'($urandom)));
    send_cmd(make_tone(8'($urandom_range(1, 6)), 16'($urandom)));
    send_cmd(make_scan(5'($urandom_range(0, 23)), 24'($urandom)));
    send_cmd(make_tone(8'($urandom_range(1, 6)), 16'($urandom)));
    assert (last_wait > 0) else plain_fail("fifth command did not wait for a credit");
    wait_idle();

    for (int i = 0; i < 6; i++) begin
      send_cmd(rand_cmd());
    end
    wait_idle();

    assert (credit_pulses == sent_count)
      else value_fail("cmd_credit pulse count", sent_count, credit_pulses);
    assert (credits == `CMD_DEPTH) else value_fail("credits at end", `CMD_DEPTH, credits);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
mtx_cmd_pkg.sv
mtx_sig_pkg.sv
cmd_intake.sv
sync_sequencer.sv
tone_gen.sv
scan_shifter.sv
gpio_map.sv
mtx_ctrl_top.sv
tb_mtx_ctrl.sv
